// ==== list.f ====
conv_acc_pkg.sv
sdp_ram.sv
out_line_buffer.sv
acc_sequencer.sv
drain_collector.sv
conv_acc_top.sv
conv_acc_properties.sv
tb_conv_acc.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_conv_acc \
	-o sim_conv_acc \
	&& ./obj_dir/sim_conv_acc \
	|| exit 1

// ==== tb_conv_acc.sv ====
`timescale 1ns/1ns

module tb_conv_acc;
	import conv_acc_pkg::*;

	localparam int CLK_HALF      = 4; // 8 ns period
	localparam int RST_CYCLES    = 16;
	localparam int MAX_GRP       = 4;
	localparam int NUM_RAND_ROWS = 6;
	localparam int NUM_ROWS      = 8 + NUM_RAND_ROWS; // drains over all tests
	localparam int ROW_BUDGET    = (MAX_GRP + 1) * MAX_W + 16; // groups, drain, slack
	localparam int CYCLE_BUDGET  = RST_CYCLES + NUM_ROWS * ROW_BUDGET;

	logic                   clk;
	logic                   rst_n;
	logic                   psum_vld;
	logic [COL_W-1:0]       psum_col;
	logic                   psum_first_grp;
	logic [NUM_CH*FT_W-1:0] psum_data;
	logic                   row_done;
	logic [ROW_W_W-1:0]     row_w;
	logic                   relu_en;
	logic                   out_vld;
	logic [COL_W-1:0]       out_col;
	logic [NUM_CH*FT_W-1:0] out_data;
	logic                   busy;

	logic [FT_W-1:0] grp_data [NUM_CH][MAX_W];  // next group to send
	logic [FT_W-1:0] model_row [NUM_CH][MAX_W]; // reference row per channel
	string test_name;
	int    cur_w;   // width of the row being drained
	int    out_cnt; // outputs seen in this drain
	int    errors;

	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	conv_acc_top i_dut (.*);

	task automatic value_mismatch(input string what, input int exp_v, input int act_v);
		errors++;
		$display("Error: %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string what);
		errors++;
		$display("%s: %s", test_name, what);
		$display("test failed");
		$fatal(1);
	endtask

	// stored sum, clamped when relu is on and the sign bit is set
	function automatic logic [FT_W-1:0] expected_lane(input int ch, input int col);
		logic [FT_W-1:0] v;
		v = model_row[ch][col];
		if (relu_en && v[FT_W-1])
			v = '0;
		return v;
	endfunction

	// compare every output strobe with the model, sampled mid cycle
	always @(negedge clk)
	begin
		if (rst_n && out_vld)
		begin
			assert (out_cnt < cur_w) else abort_run("more outputs than columns in the row");
			assert (out_col == COL_W'(out_cnt))
				else value_mismatch("out_col", out_cnt, int'(out_col));
			for (int ch = 0; ch < NUM_CH; ch++)
			begin
				assert (out_data[ch*FT_W +: FT_W] == expected_lane(ch, out_cnt))
					else value_mismatch($sformatf("ch %0d col %0d", ch, out_cnt),
						int'(expected_lane(ch, out_cnt)), int'(out_data[ch*FT_W +: FT_W]));
			end
			out_cnt++;
		end
	end

	task automatic fill_random();
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CH; ch++)
			for (int c = 0; c < MAX_W; c++)
			begin
				r = $urandom;
				grp_data[ch][c] = r[FT_W-1:0];
			end
	endtask

	// small values, negative on a checkerboard of lane and column
	task automatic fill_signed();
		logic [31:0] r;
		for (int ch = 0; ch < NUM_CH; ch++)
			for (int c = 0; c < MAX_W; c++)
			begin
				r = $urandom % 32'd5000;
				if ((c + ch) % 2 == 0)
					r = -r;
				grp_data[ch][c] = r[FT_W-1:0];
			end
	endtask

	task automatic set_width(input int w);
		row_w = ROW_W_W'(w);
		cur_w = w;
	endtask

	// one sweep over the row, model follows the overwrite-or-add rule
	task automatic send_group(input bit first, input int w);
		for (int c = 0; c < w; c++)
		begin
			psum_vld       = 1'b1;
			psum_col       = COL_W'(c);
			psum_first_grp = first;
			for (int ch = 0; ch < NUM_CH; ch++)
			begin
				psum_data[ch*FT_W +: FT_W] = grp_data[ch][c];
				if (first)
					model_row[ch][c] = grp_data[ch][c];
				else
					model_row[ch][c] = model_row[ch][c] + grp_data[ch][c]; // wraps
			end
			@(posedge clk);
			#1;
		end
		psum_vld       = 1'b0;
		psum_first_grp = 1'b0;
	endtask

	task automatic send_row(input int w, input int groups);
		set_width(w);
		for (int g = 0; g < groups; g++)
		begin
			fill_random();
			send_group(g == 0, w);
		end
	endtask

	// row_done pulse, then follow busy to the end of the drain
	task automatic drain_row(input bit junk);
		int          busy_cycles;
		logic [31:0] r;
		out_cnt     = 0;
		busy_cycles = 0;
		row_done    = 1'b1;
		@(posedge clk);
		#1;
		row_done = 1'b0;
		while (busy)
		begin
			busy_cycles++;
			if (junk)
			begin
				r              = $urandom;
				psum_vld       = 1'b1; // must be ignored while busy
				psum_col       = r[COL_W-1:0];
				psum_first_grp = r[8];
				row_done       = r[9];
				psum_data      = {NUM_CH{r[FT_W-1:0]}};
			end
			@(posedge clk);
			#1;
		end
		psum_vld = 1'b0;
		row_done = 1'b0;
		assert (busy_cycles > cur_w) else abort_run("busy fell before the drain could finish");
		assert (out_cnt == cur_w - 2)
			else value_mismatch("outputs at busy fall", cur_w - 2, out_cnt);
		repeat (2) @(posedge clk); // last result trails its read by two cycles
		#1;
		assert (out_cnt == cur_w) else value_mismatch("output count", cur_w, out_cnt);
	endtask

	task automatic single_group();
		test_name = "single_group";
		set_width(8);
		fill_random();
		send_group(1'b1, 8);
		drain_row(1'b0);
	endtask

	task automatic multi_group_accum();
		test_name = "multi_group_accum";
		send_row(16, 4);
		drain_row(1'b0);
	endtask

	task automatic first_group_overwrite();
		test_name = "first_group_overwrite";
		send_row(12, 3);
		drain_row(1'b0);
		send_row(12, 1); // old sums must be gone
		drain_row(1'b0);
	endtask

	task automatic relu_clamp();
		test_name = "relu_clamp";
		set_width(8);
		fill_signed();
		send_group(1'b1, 8);
		fill_signed();
		send_group(1'b0, 8);
		relu_en = 1'b1;
		drain_row(1'b0);
		relu_en = 1'b0; // same row again, raw values
		drain_row(1'b0);
	endtask

	task automatic ignore_while_busy();
		test_name = "ignore_while_busy";
		send_row(20, 2);
		drain_row(1'b1);
		drain_row(1'b0); // contents untouched by the junk
	endtask

	task automatic random_rows();
		int          w;
		int          g;
		logic [31:0] r;
		test_name = "random_rows";
		for (int n = 0; n < NUM_RAND_ROWS; n++)
		begin
			w = 4 + int'($urandom % (MAX_W - 3));
			g = 1 + int'($urandom % MAX_GRP);
			r = $urandom;
			relu_en = r[0];
			send_row(w, g);
			drain_row(1'b0);
		end
		relu_en = 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'hc5f4));
		rst_n = 1'b0;
		psum_vld = 1'b0;
		psum_col = '0;
		psum_first_grp = 1'b0;
		psum_data = '0;
		row_done = 1'b0;
		row_w = '0;
		relu_en = 1'b0;
		errors = 0;
		out_cnt = 0;
		cur_w = 0;
		test_name = "reset";
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		assert (!busy && !out_vld) else abort_run("busy or out_vld high after reset");
		@(posedge clk);
		#1;
		single_group();
		multi_group_accum();
		first_group_overwrite();
		relu_clamp();
		ignore_while_busy();
		random_rows();
		if (errors == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("test failed");
			$fatal(1);
		end
	end

	// twice the summed cycle budget of all tests
	initial
	begin
		repeat (2 * CYCLE_BUDGET) @(posedge clk);
		$display("timeout: the run did not complete within %0d cycles", 2 * CYCLE_BUDGET);
		$display("test failed");
		$fatal(1);
	end

endmodule

// ==== conv_acc_properties.sv ====
`timescale 1ns/1ns

module conv_acc_properties (
	input logic                              clk,
	input logic                              rst_n,
	input conv_acc_pkg::seq_state_e          state,
	input logic                              row_done,
	input logic [conv_acc_pkg::ROW_W_W-1:0]  row_w,
	input logic                              rd_vld,
	input logic [conv_acc_pkg::COL_W-1:0]    rd_col,
	input logic [conv_acc_pkg::NUM_CH-1:0]   buf_updating,
	input logic                              busy
);
	import conv_acc_pkg::*;

	// two cycles out of accum, so nothing may be in flight at the buffers
	a_no_write_outside_accum: assert property (@(posedge clk) disable iff (!rst_n)
		(state != SEQ_ACCUM) && ($past(state) != SEQ_ACCUM) |=> (buf_updating == '0))
		else $error("a buffer write was issued outside SEQ_ACCUM");

	// drain must not race a pending read-add-write
	a_no_read_while_updating: assert property (@(posedge clk) disable iff (!rst_n)
		rd_vld |-> (buf_updating == '0))
		else $error("drain read issued while a buffer was still updating");

	// leaving accum only on row_done
	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy) |-> $past(row_done))
		else $error("busy rose without a row_done pulse");

	// back to accum only after the last column was read
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(rd_vld && ({1'b0, rd_col} == row_w - 1'b1)))
		else $error("busy fell before the last column was read");

endmodule

bind acc_sequencer conv_acc_properties i_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.state        (state),
	.row_done     (row_done),
	.row_w        (row_w),
	.rd_vld       (rd_vld),
	.rd_col       (rd_col),
	.buf_updating (buf_updating),
	.busy         (busy)
);

// ==== conv_acc_top.sv ====
`timescale 1ns/1ns

module conv_acc_top (
	input  logic                                               clk,
	input  logic                                               rst_n,
	// partial sum stream
	input  logic                                               psum_vld,
	input  logic [conv_acc_pkg::COL_W-1:0]                     psum_col,
	input  logic                                               psum_first_grp,
	input  logic [conv_acc_pkg::NUM_CH*conv_acc_pkg::FT_W-1:0] psum_data,
	input  logic                                               row_done,
	input  logic [conv_acc_pkg::ROW_W_W-1:0]                   row_w,
	input  logic                                               relu_en,
	// finished row
	output logic                                               out_vld,
	output logic [conv_acc_pkg::COL_W-1:0]                     out_col,
	output logic [conv_acc_pkg::NUM_CH*conv_acc_pkg::FT_W-1:0] out_data,
	output logic                                               busy
);
	import conv_acc_pkg::*;

	logic                     buf_en;
	logic                     buf_wen;
	logic [COL_W-1:0]         buf_addr;
	logic                     buf_first_grp;
	logic [NUM_CH-1:0]        buf_updating;  // one flag per channel
	logic [NUM_CH*FT_W-1:0]   buf_dout;      // all lanes side by side
	logic                     rd_vld;
	logic [COL_W-1:0]         rd_col;

	acc_sequencer i_seq (
		.clk            (clk),
		.rst_n          (rst_n),
		.psum_vld       (psum_vld),
		.psum_col       (psum_col),
		.psum_first_grp (psum_first_grp),
		.row_done       (row_done),
		.row_w          (row_w),
		.buf_updating   (buf_updating),
		.buf_en         (buf_en),
		.buf_wen        (buf_wen),
		.buf_addr       (buf_addr),
		.buf_first_grp  (buf_first_grp),
		.rd_vld         (rd_vld),
		.rd_col         (rd_col),
		.busy           (busy)
	);

	// same address stream for all, own data lane each
	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		out_line_buffer i_buf (
			.clk           (clk),
			.rst_n         (rst_n),
			.buf_en        (buf_en),
			.buf_wen       (buf_wen),
			.buf_addr      (buf_addr),
			.buf_first_grp (buf_first_grp),
			.buf_din       (psum_data[i*FT_W +: FT_W]),
			.buf_dout      (buf_dout[i*FT_W +: FT_W]),
			.buf_updating  (buf_updating[i])
		);
	end

	drain_collector i_coll (
		.clk      (clk),
		.rst_n    (rst_n),
		.relu_en  (relu_en),
		.rd_vld   (rd_vld),
		.rd_col   (rd_col),
		.buf_dout (buf_dout),
		.out_vld  (out_vld),
		.out_col  (out_col),
		.out_data (out_data)
	);

endmodule

// ==== drain_collector.sv ====
`timescale 1ns/1ns

module drain_collector (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  logic                                          relu_en,
	// read issue from the sequencer
	input  logic                                          rd_vld,
	input  logic [conv_acc_pkg::COL_W-1:0]                rd_col,
	// ram data of all channels, one cycle after the read
	input  logic [conv_acc_pkg::NUM_CH*conv_acc_pkg::FT_W-1:0] buf_dout,
	// result strobe
	output logic                                          out_vld,
	output logic [conv_acc_pkg::COL_W-1:0]                out_col,
	output logic [conv_acc_pkg::NUM_CH*conv_acc_pkg::FT_W-1:0] out_data
);
	import conv_acc_pkg::*;

	logic             rd_vld_d;  // lines up with buf_dout
	logic [COL_W-1:0] rd_col_d;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_vld_d <= 1'b0;
			out_vld  <= 1'b0;
		end
		else
		begin
			rd_vld_d <= rd_vld;
			out_vld  <= rd_vld_d; // two cycles after the read
		end
	end

	always_ff @(posedge clk)
	begin
		rd_col_d <= rd_col;
	end

	// per lane output register with optional relu
	always_ff @(posedge clk)
	begin
		if (rd_vld_d)
		begin
			out_col <= rd_col_d;
			for (int i = 0; i < NUM_CH; i++)
			begin
				if (relu_en && buf_dout[i*FT_W+FT_W-1])
					out_data[i*FT_W +: FT_W] <= '0; // negative clamps to zero
				else
					out_data[i*FT_W +: FT_W] <= buf_dout[i*FT_W +: FT_W];
			end
		end
	end

endmodule

// ==== acc_sequencer.sv ====
`timescale 1ns/1ns

module acc_sequencer (
	input  logic                              clk,
	input  logic                              rst_n,
	// producer side
	input  logic                              psum_vld,
	input  logic [conv_acc_pkg::COL_W-1:0]    psum_col,
	input  logic                              psum_first_grp,
	input  logic                              row_done,     // pulse after the last group
	input  logic [conv_acc_pkg::ROW_W_W-1:0]  row_w,        // stable for the whole row
	// line buffers
	input  logic [conv_acc_pkg::NUM_CH-1:0]   buf_updating,
	output logic                              buf_en,
	output logic                              buf_wen,
	output logic [conv_acc_pkg::COL_W-1:0]    buf_addr,
	output logic                              buf_first_grp,
	// drain collector
	output logic                              rd_vld,
	output logic [conv_acc_pkg::COL_W-1:0]    rd_col,
	// status
	output logic                              busy
);
	import conv_acc_pkg::*;

	seq_state_e       state;
	seq_state_e       state_nxt;
	logic [COL_W-1:0] col_cnt;      // drain column
	logic             in_accum;
	logic             in_drain;
	logic             any_updating;
	logic             col_last;     // last column of the sweep
	logic [ROW_W_W-1:0] last_col;

	assign in_accum     = (state == SEQ_ACCUM);
	assign in_drain     = (state == SEQ_DRAIN);
	assign any_updating = |buf_updating; // any channel still writing back
	assign last_col     = row_w - 1'b1;
	assign col_last     = ({1'b0, col_cnt} == last_col);

	// next state
	always_comb
	begin
		state_nxt = state;
		case (state)
			SEQ_ACCUM:
			begin
				if (row_done)
					state_nxt = SEQ_WAIT;
			end
			SEQ_WAIT:
			begin
				if (!any_updating)
					state_nxt = SEQ_DRAIN; // everything has landed
			end
			SEQ_DRAIN:
			begin
				if (col_last)
					state_nxt = SEQ_ACCUM;
			end
			default:
				state_nxt = SEQ_ACCUM;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SEQ_ACCUM;
		else
			state <= state_nxt;
	end

	// column counter, back at zero after every sweep
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			col_cnt <= '0;
		else if (in_drain)
		begin
			if (col_last)
				col_cnt <= '0;
			else
				col_cnt <= col_cnt + 1'b1;
		end
	end

	// strobes pass straight through while accumulating
	assign buf_wen       = in_accum & psum_vld; // ignored while busy
	assign buf_en        = buf_wen | in_drain;
	assign buf_addr      = in_accum ? psum_col : col_cnt;
	assign buf_first_grp = in_accum & psum_first_grp;

	assign rd_vld = in_drain; // one read per drain cycle
	assign rd_col = col_cnt;
	assign busy   = ~in_accum;

endmodule

// ==== out_line_buffer.sv ====
`timescale 1ns/1ns

module out_line_buffer (
	input  logic                             clk,
	input  logic                             rst_n,
	// shared access stream from the sequencer
	input  logic                             buf_en,
	input  logic                             buf_wen,
	input  logic [conv_acc_pkg::COL_W-1:0]   buf_addr,
	input  logic                             buf_first_grp, // overwrite instead of add
	// this channel's data lane
	input  logic [conv_acc_pkg::FT_W-1:0]    buf_din,
	output logic [conv_acc_pkg::FT_W-1:0]    buf_dout,
	// a read-add-write is still in flight
	output logic                             buf_updating
);
	import conv_acc_pkg::*;

	logic            wr_stb;      // write strobe this cycle
	logic            wen_d;       // write strobe, one cycle late
	logic            wen_d2;      // write strobe, two cycles late
	logic            first_grp_d;
	logic [FT_W-1:0] din_d;
	logic [COL_W-1:0] waddr_d;
	logic [COL_W-1:0] waddr_d2;
	logic [FT_W-1:0] new_res;     // word going back into the ram
	logic            ram_ren;
	logic [FT_W-1:0] ram_dout;
	logic            updating;

	assign wr_stb = buf_en & buf_wen;

	// plain reads, and writes that need the old word
	// first group skips the read since the old word is thrown away
	assign ram_ren = buf_en & (~buf_wen | ~buf_first_grp);

	assign buf_dout     = ram_dout;
	assign buf_updating = updating;

	// write enable pipe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wen_d  <= 1'b0;
			wen_d2 <= 1'b0;
		end
		else
		begin
			wen_d  <= wr_stb;
			wen_d2 <= wen_d; // ram write at the end of this cycle
		end
	end

	// high for the two cycles after a strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			updating <= 1'b0;
		else
			updating <= wr_stb | wen_d;
	end

	// payload of the first stage, waits for the ram read
	always_ff @(posedge clk)
	begin
		if (wr_stb)
		begin
			first_grp_d <= buf_first_grp;
			din_d       <= buf_din;
			waddr_d     <= buf_addr;
		end
	end

	// second stage, old word is on ram_dout now
	always_ff @(posedge clk)
	begin
		if (wen_d)
		begin
			waddr_d2 <= waddr_d;
			new_res  <= first_grp_d ? din_d : din_d + ram_dout; // wraps at FT_W
		end
	end

	sdp_ram i_ram (
		.clk    (clk),
		.wen_a  (wen_d2),
		.addr_a (waddr_d2),
		.din_a  (new_res),
		.ren_b  (ram_ren),
		.addr_b (buf_addr),
		.dout_b (ram_dout)
	);

endmodule

// ==== sdp_ram.sv ====
`timescale 1ns/1ns

module sdp_ram (
	input  logic                             clk,
	// write port
	input  logic                             wen_a,
	input  logic [conv_acc_pkg::COL_W-1:0]   addr_a,
	input  logic [conv_acc_pkg::FT_W-1:0]    din_a,
	// read port
	input  logic                             ren_b,
	input  logic [conv_acc_pkg::COL_W-1:0]   addr_b,
	output logic [conv_acc_pkg::FT_W-1:0]    dout_b
);
	import conv_acc_pkg::*;

	logic [FT_W-1:0] mem [MAX_W]; // one word per column

	// synchronous write
	always_ff @(posedge clk)
	begin
		if (wen_a)
			mem[addr_a] <= din_a;
	end

	// registered read, holds its value while ren_b is low
	always_ff @(posedge clk)
	begin
		if (ren_b)
			dout_b <= mem[addr_b]; // old word on a same-address collision
	end

endmodule

// ==== conv_acc_pkg.sv ====
package conv_acc_pkg;

	// output channels per row
	// one line buffer for each
	localparam int NUM_CH = 4;

	// partial sum width
	// sums wrap at this width
	localparam int FT_W = 20;

	// widest row the buffers can hold
	localparam int MAX_W = 64;

	// column index width
	localparam int COL_W = $clog2(MAX_W);

	// row width input needs one more bit to hold MAX_W itself
	localparam int ROW_W_W = COL_W + 1;

	// sequencer states
	typedef enum logic [1:0]
	{
		SEQ_ACCUM = 2'd0, // taking partial sums from the producer
		SEQ_WAIT  = 2'd1, // row done, let pending writes land
		SEQ_DRAIN = 2'd2  // read sweep over the finished row
	} seq_state_e;

endpackage
